/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_core_issue
FILELIST = files.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* files.f */
source/rv_pkg.sv
source/issue_if.sv
source/reg_file.sv
source/inst_decode.sv
source/alu_exec.sv
source/core_issue_top.sv
sim/tb_core_issue.sv

/* sim/tb_core_issue.sv */
`timescale 1ns/1ns

module tb_core_issue;
  import rv_pkg::*;

  logic      clk;
  logic      rst;
  logic      inst_valid_i;
  word_t     inst_i;
  word_t     pc_i;
  logic      inst_ready_o;
  logic      result_valid_o;
  reg_addr_t result_rd_o;
  word_t     result_data_o;
  word_t     result_pc_o;
  logic      result_ready_i;
  logic      illegal_o;
  word_t     illegal_pc_o;

  // expected results and illegal pcs in program order
  reg_addr_t exp_rd_q [512];
  word_t     exp_data_q [512];
  word_t     exp_pc_q [512];
  word_t     ill_pc_q [512];
  int        res_wr;
  int        res_rd;
  int        ill_wr;
  int        ill_rd;
  int        results_seen;
  word_t     ref_regs [reg_cnt];
  word_t     model_res;
  reg_addr_t head_rd;
  word_t     head_data;
  word_t     head_pc;
  word_t     head_ill_pc;
  logic      retire_seen;
  logic [31:0] stim_state;
  logic [31:0] rdy_state;
  word_t     next_pc;
  logic      timed_out;
  int        err_value = 0;
  int        err_proto = 0;
  int        err_timeout = 0;

  core_issue_top u_core_issue_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // half the picks land on x0..x3 to provoke dependencies
  function automatic reg_addr_t pick_reg(input logic [4:0] sel);
    return sel[4] ? {2'b00, sel[3:2]} : sel[3:0];
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, op_reg};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, 1'b0, rd, opc};
  endfunction

  function automatic logic is_legal(input logic [6:0] opc);
    return opc inside {op_lui, op_auipc, op_imm, op_reg};
  endfunction

  function automatic word_t rand_inst(input logic [31:0] r1, input logic [31:0] r2);
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [6:0]  bad;
    word_t       inst;
    rd   = pick_reg(r1[31:27]);
    rs1  = pick_reg(r2[31:27]);
    rs2  = pick_reg(r2[26:22]);
    kind = r1[26:23];
    f3   = r1[22:20];
    alt  = r1[19];
    imm  = r2[21:10];
    if (kind < 4'd2) begin
      inst = enc_u(r2[21:2], rd, op_lui);
    end else if (kind < 4'd4) begin
      inst = enc_u(r2[21:2], rd, op_auipc);
    end else if (kind < 4'd9) begin
      // shifts carry only shamt and the srai bit
      if (f3 == 3'b001) begin
        imm = {7'b0, r2[14:10]};
      end else if (f3 == 3'b101) begin
        imm = {1'b0, alt, 5'b0, r2[14:10]};
      end
      inst = enc_i(imm, rs1, f3, rd, op_imm);
    end else if (kind < 4'd15) begin
      inst = enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    end else begin
      case (r2[9:8])
        2'd0:    bad = 7'b0000011;
        2'd1:    bad = 7'b0100011;
        2'd2:    bad = 7'b1100011;
        default: bad = 7'b1110011;
      endcase
      inst = {r1[31:7], bad};
    end
    return inst;
  endfunction

  // architectural result of one legal instruction against ref_regs
  function automatic word_t model_result(input word_t inst, input word_t pc);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    word_t      a;
    word_t      b;
    word_t      res;
    opc = inst[6:0];
    f3  = inst[14:12];
    alt = inst[30];
    a   = ref_regs[inst[18:15]];
    b   = (opc == op_imm) ? {{20{inst[31]}}, inst[31:20]} : ref_regs[inst[23:20]];
    case (f3)
      3'b000:  res = (opc == op_reg && alt) ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = {31'b0, $signed(a) < $signed(b)};
      3'b011:  res = {31'b0, a < b};
      3'b100:  res = a ^ b;
      3'b101:  res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    if (opc == op_lui) begin
      res = {inst[31:12], 12'h000};
    end else if (opc == op_auipc) begin
      res = pc + {inst[31:12], 12'h000};
    end
    return res;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_cnt; i++) begin
        ref_regs[i] = '0;
      end
      res_wr       <= 0;
      res_rd       <= 0;
      ill_wr       <= 0;
      ill_rd       <= 0;
      results_seen <= 0;
    end else begin
      if (inst_valid_i && inst_ready_o) begin
        if (is_legal(inst_i[6:0])) begin
          model_res = model_result(inst_i, pc_i);
          exp_rd_q[res_wr]   <= inst_i[10:7];
          exp_data_q[res_wr] <= model_res;
          exp_pc_q[res_wr]   <= pc_i;
          res_wr             <= res_wr + 1;
          if (inst_i[10:7] != 4'd0) begin
            ref_regs[inst_i[10:7]] = model_res;
          end
        end else begin
          ill_pc_q[ill_wr] <= pc_i;
          ill_wr           <= ill_wr + 1;
        end
      end
      if (retire_seen) begin
        res_rd       <= res_rd + 1;
        results_seen <= results_seen + 1;
      end
      if (illegal_o) begin
        ill_rd <= ill_rd + 1;
      end
    end
  end

  assign retire_seen = result_valid_o && result_ready_i;
  assign head_rd     = exp_rd_q[res_rd];
  assign head_data   = exp_data_q[res_rd];
  assign head_pc     = exp_pc_q[res_rd];
  assign head_ill_pc = ill_pc_q[ill_rd];

  reset_state: assert property (@(posedge clk)
    $fell(rst) |-> inst_ready_o && !result_valid_o && !illegal_o)
    else begin
      err_proto++;
      $display("%0t: outputs not idle right after reset", $time);
    end

  result_expected: assert property (@(posedge clk) disable iff (rst)
    result_valid_o |-> res_wr != res_rd)
    else begin
      err_proto++;
      $display("%0t: result_valid_o is high with no instruction outstanding", $time);
    end

  result_rd_ok: assert property (@(posedge clk) disable iff (rst)
    retire_seen |-> result_rd_o == head_rd)
    else begin
      err_value++;
      $display("[ERROR] %0t result_rd_o got %0d expected %0d",
               $time, $sampled(result_rd_o), $sampled(head_rd));
    end

  result_data_ok: assert property (@(posedge clk) disable iff (rst)
    retire_seen |-> result_data_o == head_data)
    else begin
      err_value++;
      $display("[ERROR] %0t result_data_o got %h expected %h",
               $time, $sampled(result_data_o), $sampled(head_data));
    end

  result_pc_ok: assert property (@(posedge clk) disable iff (rst)
    retire_seen |-> result_pc_o == head_pc)
    else begin
      err_value++;
      $display("[ERROR] %0t result_pc_o got %h expected %h",
               $time, $sampled(result_pc_o), $sampled(head_pc));
    end

  result_stall_hold: assert property (@(posedge clk) disable iff (rst)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_rd_o) &&
    $stable(result_data_o) && $stable(result_pc_o))
    else begin
      err_proto++;
      $display("%0t: result dropped or changed while result_ready_i was low", $time);
    end

  illegal_expected: assert property (@(posedge clk) disable iff (rst)
    illegal_o |-> ill_wr != ill_rd)
    else begin
      err_proto++;
      $display("%0t: illegal_o raised for a legal instruction", $time);
    end

  illegal_pc_ok: assert property (@(posedge clk) disable iff (rst)
    illegal_o && ill_wr != ill_rd |-> illegal_pc_o == head_ill_pc)
    else begin
      err_value++;
      $display("[ERROR] %0t illegal_pc_o got %h expected %h",
               $time, $sampled(illegal_pc_o), $sampled(head_ill_pc));
    end

  // random back-pressure about one cycle in four
  initial begin
    result_ready_i = 1'b0;
    rdy_state      = 32'd51;
    forever begin
      @(posedge clk);
      rdy_state = lcg_next(rdy_state);
      result_ready_i <= !rst && (rdy_state[31:30] != 2'b00);
    end
  end

  task automatic send_inst(input word_t inst);
    int    waited;
    word_t pc;
    waited = 0;
    pc     = next_pc;
    inst_valid_i <= 1'b1;
    inst_i       <= inst;
    pc_i         <= pc;
    next_pc = next_pc + 32'd4;
    @(posedge clk);
    while (!inst_ready_o && waited < 100) begin
      waited++;
      @(posedge clk);
    end
    if (!inst_ready_o) begin
      timed_out = 1'b1;
      err_timeout++;
      $display("%0t: instruction at pc %h was never accepted", $time, pc);
    end
    inst_valid_i <= 1'b0;
  endtask

  initial begin
    int          waited;
    logic [31:0] r1;
    logic [31:0] r2;
    rst          = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    stim_state   = 32'd51;
    next_pc      = 32'h0000_1000;
    timed_out    = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // define every register with a lui and a dependent addi
    for (int r = 1; r < reg_cnt; r++) begin
      stim_state = lcg_next(stim_state);
      send_inst(enc_u(stim_state[31:12], reg_addr_t'(r), op_lui));
      send_inst(enc_i(stim_state[27:16], reg_addr_t'(r), 3'b000, reg_addr_t'(r), op_imm));
    end

    // negative operand through srai, srli, slti, sltiu, sub and sra
    send_inst(enc_u(20'h80000, 4'd1, op_lui));
    send_inst(enc_i(12'h404, 4'd1, 3'b101, 4'd2, op_imm));
    send_inst(enc_i(12'h004, 4'd1, 3'b101, 4'd3, op_imm));
    send_inst(enc_i(12'h001, 4'd1, 3'b010, 4'd4, op_imm));
    send_inst(enc_i(12'h001, 4'd1, 3'b011, 4'd6, op_imm));
    send_inst(enc_r(7'h20, 4'd2, 4'd3, 3'b000, 4'd7));
    send_inst(enc_r(7'h20, 4'd4, 4'd1, 3'b101, 4'd8));
    // x0 must still read zero afterwards
    send_inst(enc_i(12'h123, 4'd1, 3'b000, 4'd0, op_imm));
    send_inst(enc_r(7'h00, 4'd0, 4'd0, 3'b000, 4'd5));

    for (int n = 0; n < 400 && !timed_out; n++) begin
      stim_state = lcg_next(stim_state);
      r1         = stim_state;
      stim_state = lcg_next(stim_state);
      r2         = stim_state;
      if (r1[15:13] == 3'd0) begin
        @(posedge clk);
      end
      send_inst(rand_inst(r1, r2));
    end

    waited = 0;
    while ((res_wr != res_rd || ill_wr != ill_rd) && waited < 300) begin
      waited++;
      @(posedge clk);
    end
    if (res_wr != res_rd || ill_wr != ill_rd) begin
      err_timeout++;
      $display("%0t: %0d results never retired", $time, res_wr - res_rd);
    end

    $display("errors: %0d value, %0d protocol, %0d timeout; %0d results checked",
             err_value, err_proto, err_timeout, results_seen);
    if (err_value + err_proto + err_timeout == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* source/alu_exec.sv */
`timescale 1ns/1ns

module alu_exec (
  input  logic              clk,
  input  logic              rst,
  issue_if.exec_mp          issue,
  output logic              result_valid_o,
  output rv_pkg::reg_addr_t result_rd_o,
  output rv_pkg::word_t     result_data_o,
  output rv_pkg::word_t     result_pc_o,
  input  logic              result_ready_i,
  output logic              fwd_valid_o,
  output rv_pkg::reg_addr_t fwd_rd_o,
  output rv_pkg::word_t     fwd_data_o,
  output logic              retire_o
);
  import rv_pkg::*;

  logic       held_valid;
  reg_addr_t  held_rd;
  word_t      held_data;
  word_t      held_pc;
  word_t      alu_res;
  logic [4:0] shamt;

  assign shamt = issue.op2[4:0];

  always_comb begin
    case (issue.alu_op)
      alu_add:  alu_res = issue.op1 + issue.op2;
      alu_sub:  alu_res = issue.op1 - issue.op2;
      alu_sll:  alu_res = issue.op1 << shamt;
      alu_slt:  alu_res = {31'b0, $signed(issue.op1) < $signed(issue.op2)};
      alu_sltu: alu_res = {31'b0, issue.op1 < issue.op2};
      alu_xor:  alu_res = issue.op1 ^ issue.op2;
      alu_srl:  alu_res = issue.op1 >> shamt;
      alu_sra:  alu_res = $signed(issue.op1) >>> shamt;
      alu_or:   alu_res = issue.op1 | issue.op2;
      alu_and:  alu_res = issue.op1 & issue.op2;
      default:  alu_res = issue.op1 + issue.op2;
    endcase
  end

  // take a new one when empty or when the held result leaves now
  assign issue.ready = !held_valid || result_ready_i;
  assign retire_o    = held_valid && result_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid <= 1'b0;
    end else if (issue.ready) begin
      held_valid <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid && issue.ready) begin
      held_rd   <= issue.rd;
      held_data <= alu_res;
      held_pc   <= issue.pc;
    end
  end

  assign result_valid_o = held_valid;
  assign result_rd_o    = held_rd;
  assign result_data_o  = held_data;
  assign result_pc_o    = held_pc;

  assign fwd_valid_o = held_valid;
  assign fwd_rd_o    = held_rd;
  assign fwd_data_o  = held_data;

  result_hold: assert property (@(posedge clk) disable iff (rst)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_rd_o) &&
    $stable(result_data_o) && $stable(result_pc_o));

endmodule

/* source/core_issue_top.sv */
`timescale 1ns/1ns

module core_issue_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid_i,
  input  rv_pkg::word_t     inst_i,
  input  rv_pkg::word_t     pc_i,
  output logic              inst_ready_o,
  output logic              result_valid_o,
  output rv_pkg::reg_addr_t result_rd_o,
  output rv_pkg::word_t     result_data_o,
  output rv_pkg::word_t     result_pc_o,
  input  logic              result_ready_i,
  output logic              illegal_o,
  output rv_pkg::word_t     illegal_pc_o
);
  import rv_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rdata1;
  word_t     rdata2;
  logic      busy1;
  logic      busy2;
  logic      issue_mark;
  reg_addr_t issue_rd;
  logic      fwd_valid;
  reg_addr_t fwd_rd;
  word_t     fwd_data;
  logic      retire;

  issue_if u_issue_if ();

  reg_file u_reg_file (
    .clk           (clk),
    .rst           (rst),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .rdata1_o      (rdata1),
    .rdata2_o      (rdata2),
    .busy1_o       (busy1),
    .busy2_o       (busy2),
    .issue_i       (issue_mark),
    .issue_rd_i    (issue_rd),
    .retire_i      (retire),
    .retire_rd_i   (result_rd_o),
    .retire_data_i (result_data_o)
  );

  inst_decode u_inst_decode (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .busy1_i      (busy1),
    .busy2_i      (busy2),
    .issue_o      (issue_mark),
    .issue_rd_o   (issue_rd),
    .fwd_valid_i  (fwd_valid),
    .fwd_rd_i     (fwd_rd),
    .fwd_data_i   (fwd_data),
    .illegal_o    (illegal_o),
    .illegal_pc_o (illegal_pc_o),
    .issue        (u_issue_if.decode_mp)
  );

  alu_exec u_alu_exec (
    .clk            (clk),
    .rst            (rst),
    .issue          (u_issue_if.exec_mp),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .result_pc_o    (result_pc_o),
    .result_ready_i (result_ready_i),
    .fwd_valid_o    (fwd_valid),
    .fwd_rd_o       (fwd_rd),
    .fwd_data_o     (fwd_data),
    .retire_o       (retire)
  );

endmodule

/* source/inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     inst_i,
  input  rv_pkg::word_t     pc_i,
  input  logic              inst_valid_i,
  output logic              inst_ready_o,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  input  rv_pkg::word_t     rdata1_i,
  input  rv_pkg::word_t     rdata2_i,
  input  logic              busy1_i,
  input  logic              busy2_i,
  output logic              issue_o,
  output rv_pkg::reg_addr_t issue_rd_o,
  input  logic              fwd_valid_i,
  input  rv_pkg::reg_addr_t fwd_rd_i,
  input  rv_pkg::word_t     fwd_data_i,
  output logic              illegal_o,
  output rv_pkg::word_t     illegal_pc_o,
  issue_if.decode_mp        issue
);
  import rv_pkg::*;

  word_t inst_q;
  word_t pc_q;
  logic  valid_q;

  logic [6:0] opcode;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;

  logic    legal;
  logic    uses_rs1;
  logic    uses_rs2;
  logic    fwd1;
  logic    fwd2;
  logic    hazard;
  logic    fire;
  word_t   src1;
  word_t   src2;
  alu_op_t alu_op;
  word_t   op1;
  word_t   op2;

  // field extraction, RV32E keeps only the low four register bits
  assign opcode = inst_q[6:0];
  assign rd     = inst_q[10:7];
  assign funct3 = inst_q[14:12];
  assign rs1    = inst_q[18:15];
  assign rs2    = inst_q[23:20];
  assign funct7 = inst_q[31:25];
  assign imm_i  = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_u  = {inst_q[31:12], 12'b0};

  assign legal = (opcode == op_lui) || (opcode == op_auipc) ||
                 (opcode == op_imm) || (opcode == op_reg);
  assign uses_rs1 = (opcode == op_imm) || (opcode == op_reg);
  assign uses_rs2 = (opcode == op_reg);

  // bypass the held execute result; x0 is never forwarded
  assign fwd1 = fwd_valid_i && rs1 != '0 && fwd_rd_i == rs1;
  assign fwd2 = fwd_valid_i && rs2 != '0 && fwd_rd_i == rs2;
  assign src1 = fwd1 ? fwd_data_i : rdata1_i;
  assign src2 = fwd2 ? fwd_data_i : rdata2_i;

  assign hazard = (uses_rs1 && busy1_i && !fwd1) ||
                  (uses_rs2 && busy2_i && !fwd2);

  always_comb begin
    alu_op = alu_add;
    op1    = '0;
    op2    = '0;
    case (opcode)
      op_lui: begin
        op2 = imm_u;
      end
      op_auipc: begin
        op1 = pc_q;
        op2 = imm_u;
      end
      op_imm: begin
        // funct7 bit only selects srai over srli
        alu_op = alu_op_t'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        op1    = src1;
        op2    = imm_i;
      end
      op_reg: begin
        alu_op = alu_op_t'({funct7[5], funct3});
        op1    = src1;
        op2    = src2;
      end
      default: begin
        alu_op = alu_add;
      end
    endcase
  end

  assign issue.valid  = valid_q && legal && !hazard;
  assign issue.alu_op = alu_op;
  assign issue.op1    = op1;
  assign issue.op2    = op2;
  assign issue.rd     = rd;
  assign issue.pc     = pc_q;

  assign fire = issue.valid && issue.ready;

  // slot frees on transfer, or right away for an illegal opcode
  assign inst_ready_o = !valid_q || fire || !legal;

  assign illegal_o    = valid_q && !legal;
  assign illegal_pc_o = pc_q;

  assign rs1_o      = rs1;
  assign rs2_o      = rs2;
  assign issue_o    = fire;
  assign issue_rd_o = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_ready_o && inst_valid_i) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // offered instruction must not change under back-pressure
  issue_hold: assert property (@(posedge clk) disable iff (rst)
    issue.valid && !issue.ready |=> issue.valid && $stable(issue.alu_op) &&
    $stable(issue.op1) && $stable(issue.op2) && $stable(issue.rd) && $stable(issue.pc));

endmodule

/* source/issue_if.sv */
`timescale 1ns/1ns

interface issue_if;
  import rv_pkg::*;

  logic      valid;
  logic      ready;
  alu_op_t   alu_op;
  word_t     op1;
  word_t     op2;
  reg_addr_t rd;
  word_t     pc;

  // decode offers, execute takes
  modport decode_mp (
    output valid, alu_op, op1, op2, rd, pc,
    input  ready
  );

  modport exec_mp (
    input  valid, alu_op, op1, op2, rd, pc,
    output ready
  );

endinterface

/* source/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  output rv_pkg::word_t     rdata1_o,
  output rv_pkg::word_t     rdata2_o,
  output logic              busy1_o,
  output logic              busy2_o,
  input  logic              issue_i,
  input  rv_pkg::reg_addr_t issue_rd_i,
  input  logic              retire_i,
  input  rv_pkg::reg_addr_t retire_rd_i,
  input  rv_pkg::word_t     retire_data_i
);
  import rv_pkg::*;

  word_t     regs [reg_cnt];
  // outstanding writers per register, at most two in flight
  logic [1:0] busy_cnt [reg_cnt];

  logic      wr_pend;
  reg_addr_t wr_rd;
  word_t     wr_data;

  // retired result waits one cycle before it lands
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= retire_i;
    end
  end

  always_ff @(posedge clk) begin
    wr_rd   <= retire_rd_i;
    wr_data <= retire_data_i;
  end

  always_ff @(posedge clk) begin
    if (wr_pend && wr_rd != '0) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // x0 never counted
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_cnt; i++) begin
        busy_cnt[i] <= 2'd0;
      end
    end else begin
      for (int i = 1; i < reg_cnt; i++) begin
        if ((issue_i && issue_rd_i == reg_addr_t'(i)) &&
            !(wr_pend && wr_rd == reg_addr_t'(i))) begin
          busy_cnt[i] <= busy_cnt[i] + 2'd1;
        end else if (!(issue_i && issue_rd_i == reg_addr_t'(i)) &&
                     (wr_pend && wr_rd == reg_addr_t'(i))) begin
          busy_cnt[i] <= busy_cnt[i] - 2'd1;
        end
      end
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
  assign busy1_o  = busy_cnt[rs1_i] != 2'd0;
  assign busy2_o  = busy_cnt[rs2_i] != 2'd0;

  // execute only retires what decode marked at issue
  retire_was_marked: assert property (@(posedge clk) disable iff (rst)
    retire_i && retire_rd_i != '0 |-> busy_cnt[retire_rd_i] != 2'd0);

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  // datapath and register file geometry
  localparam int xlen    = 32;
  localparam int reg_cnt = 16;
  localparam int reg_aw  = 4;

  // supported major opcodes
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_reg   = 7'b0110011;

  typedef logic [xlen-1:0]   word_t;
  typedef logic [reg_aw-1:0] reg_addr_t;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_t;

endpackage
